/* verilog/fetch_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read channel beats, redirect type and RV32I/Zicsr encodings
// shared by all modules of the fetch subsystem through scoped names
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fetch_pkg;

	// read address beat
	typedef struct packed {
		logic [31:0] addr;
	} rd_req_t;

	// read data beat
	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} rd_rsp_t;

	// one redirect source, sampled with retire
	typedef struct packed {
		logic        take;
		logic [31:0] target;
	} redirect_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct3 fields
	localparam logic [2:0] F3_JALR  = 3'b000;
	localparam logic [2:0] F3_LB    = 3'b000;
	localparam logic [2:0] F3_LH    = 3'b001;
	localparam logic [2:0] F3_LW    = 3'b010;
	localparam logic [2:0] F3_LBU   = 3'b100;
	localparam logic [2:0] F3_LHU   = 3'b101;
	localparam logic [2:0] F3_SB    = 3'b000;
	localparam logic [2:0] F3_SH    = 3'b001;
	localparam logic [2:0] F3_SW    = 3'b010;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	// srli and srai share this one, funct7 tells them apart
	localparam logic [2:0] F3_SRXI  = 3'b101;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;

	// full system words
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

/* verilog/pc_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, updated once per retired instruction
// redirect priority is trap, jump, branch, then pc + 4
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pc_gen (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 advance_i,
	input  fetch_pkg::redirect_t trap_i,
	input  fetch_pkg::redirect_t jump_i,
	input  fetch_pkg::redirect_t branch_i,
	output logic [31:0]          pc_o
);

	logic [31:0] pc_q;
	logic [31:0] pc_next;

	// highest taken source wins
	always_comb begin
		if (trap_i.take) begin
			pc_next = trap_i.target;
		end else if (jump_i.take) begin
			pc_next = jump_i.target;
		end else if (branch_i.take) begin
			pc_next = branch_i.target;
		end else begin
			pc_next = pc_q + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else if (advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

/* verilog/inst_check.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational legality check against the RV32I/Zicsr subset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module inst_check (
	input  logic [31:0] inst_i,
	output logic        illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			fetch_pkg::OPC_LUI,
			fetch_pkg::OPC_AUIPC,
			fetch_pkg::OPC_JAL,
			fetch_pkg::OPC_BRANCH,
			fetch_pkg::OPC_OP: legal = 1'b1;
			fetch_pkg::OPC_JALR: legal = (funct3 == fetch_pkg::F3_JALR);
			fetch_pkg::OPC_LOAD: begin
				legal = funct3 inside {fetch_pkg::F3_LB, fetch_pkg::F3_LH, fetch_pkg::F3_LW,
					fetch_pkg::F3_LBU, fetch_pkg::F3_LHU};
			end
			fetch_pkg::OPC_STORE: begin
				legal = funct3 inside {fetch_pkg::F3_SB, fetch_pkg::F3_SH, fetch_pkg::F3_SW};
			end
			fetch_pkg::OPC_OP_IMM: begin
				// shifts carry funct7 in the immediate
				if (funct3 == fetch_pkg::F3_SLLI) begin
					legal = (funct7 == fetch_pkg::F7_BASE);
				end else if (funct3 == fetch_pkg::F3_SRXI) begin
					legal = (funct7 == fetch_pkg::F7_BASE) || (funct7 == fetch_pkg::F7_ALT);
				end else begin
					legal = 1'b1;
				end
			end
			fetch_pkg::OPC_SYSTEM: begin
				legal = (funct3 inside {fetch_pkg::F3_CSRRW, fetch_pkg::F3_CSRRS}) ||
					(inst_i == fetch_pkg::INST_ECALL) ||
					(inst_i == fetch_pkg::INST_EBREAK) ||
					(inst_i == fetch_pkg::INST_MRET);
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal_o = !legal;

endmodule

/* verilog/ifetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch unit, reads one word per retired instruction over the read
// channel and reports it with a one-cycle inst_valid_o
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ifetch (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 retire_i,
	input  fetch_pkg::redirect_t trap_i,
	input  fetch_pkg::redirect_t jump_i,
	input  fetch_pkg::redirect_t branch_i,
	output fetch_pkg::rd_req_t   ar_o,
	output logic                 ar_valid_o,
	input  logic                 ar_ready_i,
	input  fetch_pkg::rd_rsp_t   r_i,
	input  logic                 r_valid_i,
	output logic                 r_ready_o,
	output logic                 inst_valid_o,
	output logic [31:0]          inst_o,
	output logic [31:0]          pc_o,
	output logic                 illegal_o,
	output logic                 fault_o
);

	typedef enum logic [1:0] {
		S_ADDR,
		S_DATA,
		S_REPORT,
		S_RETIRE
	} state_t;

	state_t      state_q;
	state_t      state_d;
	logic        advance;
	logic [31:0] pc;
	logic [31:0] inst_q;
	logic        fault_q;

	// retire is taken as soon as the word has been reported
	assign advance = retire_i && ((state_q == S_REPORT) || (state_q == S_RETIRE));

	pc_gen i_pc_gen (
		.clk       (clk),
		.rst       (rst),
		.advance_i (advance),
		.trap_i    (trap_i),
		.jump_i    (jump_i),
		.branch_i  (branch_i),
		.pc_o      (pc)
	);

	inst_check i_inst_check (
		.inst_i    (inst_q),
		.illegal_o (illegal_o)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_ADDR:   if (ar_valid_o && ar_ready_i) state_d = S_DATA;
			S_DATA:   if (r_valid_i && r_ready_o) state_d = S_REPORT;
			S_REPORT: state_d = advance ? S_ADDR : S_RETIRE;
			S_RETIRE: if (advance) state_d = S_ADDR;
			default:  state_d = S_ADDR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// returned word, held until the next fetch completes
	always_ff @(posedge clk) begin
		if (r_valid_i && r_ready_o) begin
			inst_q  <= r_i.data;
			fault_q <= (r_i.resp != fetch_pkg::RESP_OKAY);
		end
	end

	assign ar_o.addr    = pc;
	assign ar_valid_o   = (state_q == S_ADDR);
	assign r_ready_o    = (state_q == S_DATA);
	assign inst_valid_o = (state_q == S_REPORT);
	assign inst_o       = inst_q;
	assign pc_o         = pc;
	assign fault_o      = fault_q;

endmodule

/* verilog/load_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data load master, one read per load_req_i pulse taken while idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module load_port (
	input  logic               clk,
	input  logic               rst,
	input  logic               load_req_i,
	input  logic [31:0]        load_addr_i,
	output logic               busy_o,
	output logic               load_done_o,
	output logic [31:0]        load_data_o,
	output logic               load_err_o,
	output fetch_pkg::rd_req_t ar_o,
	output logic               ar_valid_o,
	input  logic               ar_ready_i,
	input  fetch_pkg::rd_rsp_t r_i,
	input  logic               r_valid_i,
	output logic               r_ready_o
);

	typedef enum logic [1:0] {
		L_IDLE,
		L_ADDR,
		L_DATA
	} state_t;

	state_t      state_q;
	logic        done_q;
	logic [31:0] addr_q;
	logic [31:0] data_q;
	logic        err_q;
	logic        r_fire;

	assign r_fire = r_valid_i && r_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= L_IDLE;
			done_q  <= 1'b0;
		end else begin
			done_q <= r_fire;
			case (state_q)
				L_IDLE: if (load_req_i) state_q <= L_ADDR;
				L_ADDR: if (ar_valid_o && ar_ready_i) state_q <= L_DATA;
				L_DATA: if (r_fire) state_q <= L_IDLE;
				default: state_q <= L_IDLE;
			endcase
		end
	end

	// request address and result
	always_ff @(posedge clk) begin
		if ((state_q == L_IDLE) && load_req_i) begin
			addr_q <= load_addr_i;
		end
		if (r_fire) begin
			data_q <= r_i.data;
			err_q  <= (r_i.resp != fetch_pkg::RESP_OKAY);
		end
	end

	assign busy_o      = (state_q != L_IDLE);
	assign ar_o.addr   = addr_q;
	assign ar_valid_o  = (state_q == L_ADDR);
	assign r_ready_o   = (state_q == L_DATA);
	assign load_done_o = done_q;
	assign load_data_o = data_q;
	assign load_err_o  = err_q;

endmodule

/* verilog/rd_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin arbiter between fetch and load read masters
// a grant lasts from address acceptance up to the read response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rd_arbiter (
	input  logic               clk,
	input  logic               rst,
	input  fetch_pkg::rd_req_t f_ar_i,
	input  logic               f_ar_valid_i,
	output logic               f_ar_ready_o,
	output fetch_pkg::rd_rsp_t f_r_o,
	output logic               f_r_valid_o,
	input  logic               f_r_ready_i,
	input  fetch_pkg::rd_req_t l_ar_i,
	input  logic               l_ar_valid_i,
	output logic               l_ar_ready_o,
	output fetch_pkg::rd_rsp_t l_r_o,
	output logic               l_r_valid_o,
	input  logic               l_r_ready_i,
	output fetch_pkg::rd_req_t m_ar_o,
	output logic               m_ar_valid_o,
	input  logic               m_ar_ready_i,
	input  fetch_pkg::rd_rsp_t m_r_i,
	input  logic               m_r_valid_i,
	output logic               m_r_ready_o
);

	// one-hot grant, bit 0 fetch and bit 1 load, zero while idle
	logic [1:0] gnt_q;
	// set when load won the last round
	logic       last_q;
	logic       pick_load;
	logic       r_fire;

	assign pick_load = l_ar_valid_i && (!f_ar_valid_i || !last_q);
	assign r_fire    = m_r_valid_i && m_r_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt_q  <= 2'b00;
			last_q <= 1'b1;
		end else if (gnt_q == 2'b00) begin
			if (f_ar_valid_i || l_ar_valid_i) begin
				gnt_q  <= pick_load ? 2'b10 : 2'b01;
				last_q <= pick_load;
			end
		end else if (r_fire) begin
			gnt_q <= 2'b00;
		end
	end

	// address channel steering
	assign m_ar_o       = gnt_q[1] ? l_ar_i : f_ar_i;
	assign m_ar_valid_o = (gnt_q[0] && f_ar_valid_i) || (gnt_q[1] && l_ar_valid_i);
	assign f_ar_ready_o = gnt_q[0] && m_ar_ready_i;
	assign l_ar_ready_o = gnt_q[1] && m_ar_ready_i;

	// data channel steering
	assign f_r_o       = m_r_i;
	assign l_r_o       = m_r_i;
	assign f_r_valid_o = gnt_q[0] && m_r_valid_i;
	assign l_r_valid_o = gnt_q[1] && m_r_valid_i;
	assign m_r_ready_o = (gnt_q[0] && f_r_ready_i) || (gnt_q[1] && l_r_ready_i);

endmodule

/* verilog/mem_slave.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word memory behind the read channel, latency of 1 to 4 cycles
// picked by an LFSR, plus a loader write port that never stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_slave #(
	parameter int         MEM_WORDS = 256,
	parameter logic [3:0] LAT_SEED  = 4'h9
) (
	input  logic               clk,
	input  logic               rst,
	input  fetch_pkg::rd_req_t ar_i,
	input  logic               ar_valid_i,
	output logic               ar_ready_o,
	output fetch_pkg::rd_rsp_t r_o,
	output logic               r_valid_o,
	input  logic               r_ready_i,
	input  logic               mem_we_i,
	input  logic [31:0]        mem_waddr_i,
	input  logic [31:0]        mem_wdata_i
);

	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0]   mem [MEM_WORDS];
	logic          busy_q;
	logic [1:0]    cnt_q;
	logic [3:0]    lfsr_q;
	logic [3:0]    lfsr_next;
	logic [AW-1:0] idx_q;
	logic          err_q;
	logic          ar_fire;

	// x^4 + x^3 + 1
	assign lfsr_next = {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
	assign ar_fire   = ar_valid_i && ar_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q  <= 2'd0;
			lfsr_q <= LAT_SEED;
		end else if (ar_fire) begin
			busy_q <= 1'b1;
			cnt_q  <= lfsr_next[1:0];
			lfsr_q <= lfsr_next;
		end else if (r_valid_o && r_ready_i) begin
			busy_q <= 1'b0;
		end else if (busy_q && (cnt_q != 2'd0)) begin
			cnt_q <= cnt_q - 2'd1;
		end
	end

	// word index and range check of the accepted address
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			idx_q <= ar_i.addr[AW+1:2];
			err_q <= ({2'b00, ar_i.addr[31:2]} >= 32'(MEM_WORDS));
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we_i && ({2'b00, mem_waddr_i[31:2]} < 32'(MEM_WORDS))) begin
			mem[mem_waddr_i[AW+1:2]] <= mem_wdata_i;
		end
	end

	assign ar_ready_o = !busy_q;
	assign r_valid_o  = busy_q && (cnt_q == 2'd0);
	assign r_o.data   = err_q ? 32'h0 : mem[idx_q];
	assign r_o.resp   = err_q ? fetch_pkg::RESP_SLVERR : fetch_pkg::RESP_OKAY;

endmodule

/* verilog/fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch subsystem top, fetch unit and load port sharing one memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_top #(
	parameter int         MEM_WORDS = 256,
	parameter logic [3:0] LAT_SEED  = 4'h9
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 retire_i,
	input  fetch_pkg::redirect_t trap_i,
	input  fetch_pkg::redirect_t jump_i,
	input  fetch_pkg::redirect_t branch_i,
	output logic                 inst_valid_o,
	output logic [31:0]          inst_o,
	output logic [31:0]          pc_o,
	output logic                 illegal_o,
	output logic                 fault_o,
	input  logic                 load_req_i,
	input  logic [31:0]          load_addr_i,
	output logic                 busy_o,
	output logic                 load_done_o,
	output logic [31:0]          load_data_o,
	output logic                 load_err_o,
	input  logic                 mem_we_i,
	input  logic [31:0]          mem_waddr_i,
	input  logic [31:0]          mem_wdata_i
);

	// fetch side
	fetch_pkg::rd_req_t f_ar;
	fetch_pkg::rd_rsp_t f_r;
	logic               f_ar_valid;
	logic               f_ar_ready;
	logic               f_r_valid;
	logic               f_r_ready;

	// load side
	fetch_pkg::rd_req_t l_ar;
	fetch_pkg::rd_rsp_t l_r;
	logic               l_ar_valid;
	logic               l_ar_ready;
	logic               l_r_valid;
	logic               l_r_ready;

	// memory side
	fetch_pkg::rd_req_t m_ar;
	fetch_pkg::rd_rsp_t m_r;
	logic               m_ar_valid;
	logic               m_ar_ready;
	logic               m_r_valid;
	logic               m_r_ready;

	ifetch i_ifetch (
		.clk          (clk),
		.rst          (rst),
		.retire_i     (retire_i),
		.trap_i       (trap_i),
		.jump_i       (jump_i),
		.branch_i     (branch_i),
		.ar_o         (f_ar),
		.ar_valid_o   (f_ar_valid),
		.ar_ready_i   (f_ar_ready),
		.r_i          (f_r),
		.r_valid_i    (f_r_valid),
		.r_ready_o    (f_r_ready),
		.inst_valid_o (inst_valid_o),
		.inst_o       (inst_o),
		.pc_o         (pc_o),
		.illegal_o    (illegal_o),
		.fault_o      (fault_o)
	);

	load_port i_load_port (
		.clk         (clk),
		.rst         (rst),
		.load_req_i  (load_req_i),
		.load_addr_i (load_addr_i),
		.busy_o      (busy_o),
		.load_done_o (load_done_o),
		.load_data_o (load_data_o),
		.load_err_o  (load_err_o),
		.ar_o        (l_ar),
		.ar_valid_o  (l_ar_valid),
		.ar_ready_i  (l_ar_ready),
		.r_i         (l_r),
		.r_valid_i   (l_r_valid),
		.r_ready_o   (l_r_ready)
	);

	rd_arbiter i_rd_arbiter (
		.clk          (clk),
		.rst          (rst),
		.f_ar_i       (f_ar),
		.f_ar_valid_i (f_ar_valid),
		.f_ar_ready_o (f_ar_ready),
		.f_r_o        (f_r),
		.f_r_valid_o  (f_r_valid),
		.f_r_ready_i  (f_r_ready),
		.l_ar_i       (l_ar),
		.l_ar_valid_i (l_ar_valid),
		.l_ar_ready_o (l_ar_ready),
		.l_r_o        (l_r),
		.l_r_valid_o  (l_r_valid),
		.l_r_ready_i  (l_r_ready),
		.m_ar_o       (m_ar),
		.m_ar_valid_o (m_ar_valid),
		.m_ar_ready_i (m_ar_ready),
		.m_r_i        (m_r),
		.m_r_valid_i  (m_r_valid),
		.m_r_ready_o  (m_r_ready)
	);

	mem_slave #(
		.MEM_WORDS (MEM_WORDS),
		.LAT_SEED  (LAT_SEED)
	) i_mem_slave (
		.clk         (clk),
		.rst         (rst),
		.ar_i        (m_ar),
		.ar_valid_i  (m_ar_valid),
		.ar_ready_o  (m_ar_ready),
		.r_o         (m_r),
		.r_valid_o   (m_r_valid),
		.r_ready_i   (m_r_ready),
		.mem_we_i    (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i)
	);

endmodule

/* verification/fetch_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the memory side of the read arbiter
// bound into every rd_arbiter instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rd_arbiter_assert (
	input logic               clk,
	input logic               rst,
	input logic [1:0]         gnt_i,
	input fetch_pkg::rd_req_t ar_i,
	input logic               ar_valid_i,
	input logic               ar_ready_i,
	input fetch_pkg::rd_rsp_t r_i,
	input logic               r_valid_i,
	input logic               r_ready_i
);

	// number of failed checks
	int fail_count = 0;

	// a new grant is taken by an address beat at once
	grant_used: assert property (@(posedge clk) disable iff (rst)
		((gnt_i != 2'b00) && ($past(gnt_i) == 2'b00)) |-> (ar_valid_i && ar_ready_i))
		else begin
			fail_count++;
			$error("new grant was not used by an address transfer");
		end

	addr_held: assert property (@(posedge clk) disable iff (rst)
		(ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_i)))
		else begin
			fail_count++;
			$error("address valid dropped or changed before acceptance");
		end

	data_held: assert property (@(posedge clk) disable iff (rst)
		(r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_i)))
		else begin
			fail_count++;
			$error("read data valid dropped or changed before ready");
		end

	data_granted: assert property (@(posedge clk) disable iff (rst)
		r_valid_i |-> (gnt_i != 2'b00))
		else begin
			fail_count++;
			$error("read data returned with no master granted");
		end

endmodule

bind rd_arbiter rd_arbiter_assert i_rd_arbiter_assert (
	.clk        (clk),
	.rst        (rst),
	.gnt_i      (gnt_q),
	.ar_i       (m_ar_o),
	.ar_valid_i (m_ar_valid_o),
	.ar_ready_i (m_ar_ready_i),
	.r_i        (m_r_i),
	.r_valid_i  (m_r_valid_i),
	.r_ready_i  (m_r_ready_o)
);

/* verification/fetch_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the fetch subsystem, covers fetch order,
// redirects, legality, faults and loads sharing the read channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_tb;

	localparam int          MEM_WORDS    = 256;
	localparam logic [3:0]  LAT_SEED     = 4'h9;
	localparam int unsigned RAND_SEED    = 32'h8a5c_e7fa;
	localparam int          RESET_CYCLES = 4;
	// a fetch or load with contention finishes well within one step
	localparam int          STEP_CYCLES  = 16;
	localparam int          MAX_STEPS    = 20;
	localparam int          N_TESTS      = 5;
	localparam int          MAX_CYCLES   = RESET_CYCLES + MEM_WORDS +
		N_TESTS * MAX_STEPS * STEP_CYCLES;
	// word index of the legality test block
	localparam int          LEGAL_BASE   = 224;
	localparam int          N_LEGAL      = 18;

	logic                 clk;
	logic                 rst;
	logic                 retire;
	fetch_pkg::redirect_t trap;
	fetch_pkg::redirect_t jump;
	fetch_pkg::redirect_t branch;
	logic                 inst_valid;
	logic [31:0]          inst;
	logic [31:0]          pc;
	logic                 illegal;
	logic                 fault;
	logic                 load_req;
	logic [31:0]          load_addr;
	logic                 busy;
	logic                 load_done;
	logic [31:0]          load_data;
	logic                 load_err;
	logic                 mem_we;
	logic [31:0]          mem_waddr;
	logic [31:0]          mem_wdata;

	// expected memory contents, updated with every loader write
	logic [31:0] mem_model [MEM_WORDS];
	int          check_count;
	int          error_count;
	int          cycle_count;
	int          assert_fails;

	fetch_top #(
		.MEM_WORDS (MEM_WORDS),
		.LAT_SEED  (LAT_SEED)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.retire_i     (retire),
		.trap_i       (trap),
		.jump_i       (jump),
		.branch_i     (branch),
		.inst_valid_o (inst_valid),
		.inst_o       (inst),
		.pc_o         (pc),
		.illegal_o    (illegal),
		.fault_o      (fault),
		.load_req_i   (load_req),
		.load_addr_i  (load_addr),
		.busy_o       (busy),
		.load_done_o  (load_done),
		.load_data_o  (load_data),
		.load_err_o   (load_err),
		.mem_we_i     (mem_we),
		.mem_waddr_i  (mem_waddr),
		.mem_wdata_i  (mem_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("checks: %0d, errors: %0d", check_count, error_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// inputs change 1 ns after the rising edge, outputs are read there too
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("** Error: %s = 0x%h, expected 0x%h (time %0t)", name, got, exp, $time);
		end
	endtask

	// every word is a LUI, bits above the opcode mix in the whole index
	function automatic logic [31:0] fill_word(input int idx);
		return {25'(idx * 32'h0001_9e37 + 32'h0000_5a5a), 7'b0110111};
	endfunction

	function automatic logic [31:0] encode_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic fetch_pkg::redirect_t make_redirect(input logic take,
		input logic [31:0] target);
		fetch_pkg::redirect_t r;
		r.take   = take;
		r.target = target;
		return r;
	endfunction

	task automatic write_word(input int idx, input logic [31:0] data);
		mem_we    = 1'b1;
		mem_waddr = 32'(idx) << 2;
		mem_wdata = data;
		mem_model[idx] = data;
		tick();
		mem_we = 1'b0;
	endtask

	task automatic fill_range(input int lo, input int hi);
		for (int k = lo; k <= hi; k++) begin
			write_word(k, fill_word(k));
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		// first words go in while reset is held
		for (int k = 0; k < RESET_CYCLES; k++) begin
			write_word(k, fill_word(k));
		end
		rst = 1'b0;
	endtask

	task automatic retire_with(input fetch_pkg::redirect_t t, input fetch_pkg::redirect_t j,
		input fetch_pkg::redirect_t b);
		retire = 1'b1;
		trap   = t;
		jump   = j;
		branch = b;
		tick();
		retire = 1'b0;
		trap   = '0;
		jump   = '0;
		branch = '0;
	endtask

	task automatic expect_fetch(input logic [31:0] exp_pc, input logic exp_illegal);
		logic        in_range;
		logic [31:0] exp_inst;
		in_range = (exp_pc >> 2) < 32'(MEM_WORDS);
		exp_inst = 32'h0;
		if (in_range) begin
			exp_inst = mem_model[int'(exp_pc >> 2)];
		end
		while (!inst_valid) begin
			tick();
		end
		check_value("pc_o", pc, exp_pc);
		check_value("inst_o", inst, exp_inst);
		check_value("fault_o", 32'(fault), 32'(!in_range));
		check_value("illegal_o", 32'(illegal), 32'(exp_illegal));
	endtask

	task automatic run_load(input logic [31:0] addr);
		logic        exp_err;
		logic [31:0] exp_data;
		while (busy) begin
			tick();
		end
		load_req  = 1'b1;
		load_addr = addr;
		tick();
		load_req = 1'b0;
		while (!load_done) begin
			tick();
		end
		exp_err  = (addr >> 2) >= 32'(MEM_WORDS);
		exp_data = 32'h0;
		if (!exp_err) begin
			exp_data = mem_model[int'(addr >> 2)];
		end
		check_value("load_err_o", 32'(load_err), 32'(exp_err));
		check_value("load_data_o", load_data, exp_data);
	endtask

	task automatic check_reset_state();
		check_value("inst_valid_o", 32'(inst_valid), 32'h0);
		check_value("load_done_o", 32'(load_done), 32'h0);
		check_value("busy_o", 32'(busy), 32'h0);
		check_value("pc_o", pc, fetch_pkg::RESET_PC);
		check_value("f_ar_valid", 32'(i_dut.f_ar_valid), 32'h1);
	endtask

	task automatic test_sequential();
		for (int k = 0; k < RESET_CYCLES; k++) begin
			if (k > 0) begin
				retire_with('0, '0, '0);
			end
			expect_fetch(fetch_pkg::RESET_PC + 32'(4 * k), 1'b0);
			// one-cycle pulse, then the word is held until retire
			tick();
			check_value("inst_valid_o", 32'(inst_valid), 32'h0);
			check_value("pc_o", pc, fetch_pkg::RESET_PC + 32'(4 * k));
		end
	endtask

	task automatic test_redirect_priority();
		retire_with(make_redirect(1'b1, 32'h100), make_redirect(1'b1, 32'h204),
			make_redirect(1'b1, 32'h308));
		expect_fetch(32'h100, 1'b0);
		// targets of sources not taken must be ignored
		retire_with(make_redirect(1'b0, 32'h10c), make_redirect(1'b1, 32'h214),
			make_redirect(1'b1, 32'h318));
		expect_fetch(32'h214, 1'b0);
		retire_with(make_redirect(1'b0, 32'h11c), make_redirect(1'b0, 32'h224),
			make_redirect(1'b1, 32'h328));
		expect_fetch(32'h328, 1'b0);
	endtask

	task automatic test_legality();
		logic [31:0] words [N_LEGAL];
		logic        bad [N_LEGAL];
		words[0]  = encode_word(7'h05, 5'd10, 5'd3, 3'd6, 5'd1, 7'b0110111);
		words[1]  = encode_word(7'h41, 5'd2, 5'd9, 3'd7, 5'd4, 7'b0010111);
		words[2]  = encode_word(7'h7f, 5'd31, 5'd1, 3'd3, 5'd1, 7'b1101111);
		words[3]  = encode_word(7'h00, 5'd8, 5'd5, 3'b000, 5'd1, 7'b1100111);
		words[4]  = encode_word(7'h12, 5'd6, 5'd7, 3'b110, 5'd2, 7'b1100011);
		words[5]  = encode_word(7'h01, 5'd4, 5'd2, 3'b010, 5'd3, 7'b0000011);
		words[6]  = encode_word(7'h00, 5'd4, 5'd2, 3'b101, 5'd3, 7'b0000011);
		words[7]  = encode_word(7'h02, 5'd5, 5'd2, 3'b010, 5'd8, 7'b0100011);
		words[8]  = encode_word(7'h7f, 5'd31, 5'd3, 3'b000, 5'd3, 7'b0010011);
		words[9]  = encode_word(7'h20, 5'd4, 5'd6, 3'b101, 5'd6, 7'b0010011);
		words[10] = encode_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011);
		// csrrs on mstatus
		words[11] = encode_word(7'h18, 5'd0, 5'd0, 3'b010, 5'd5, 7'b1110011);
		words[12] = 32'h0000_0073;
		words[13] = 32'h0010_0073;
		words[14] = 32'h3020_0073;
		// fence, slli with funct7 set, all zero
		words[15] = 32'h0ff0_000f;
		words[16] = encode_word(7'h20, 5'd3, 5'd1, 3'b001, 5'd2, 7'b0010011);
		words[17] = 32'h0000_0000;
		for (int k = 0; k < N_LEGAL; k++) begin
			bad[k] = (k >= 15);
			write_word(LEGAL_BASE + k, words[k]);
		end
		retire_with('0, make_redirect(1'b1, 32'(LEGAL_BASE * 4)), '0);
		for (int k = 0; k < N_LEGAL; k++) begin
			if (k > 0) begin
				retire_with('0, '0, '0);
			end
			expect_fetch(32'(LEGAL_BASE * 4 + 4 * k), bad[k]);
		end
	endtask

	task automatic test_fault();
		retire_with('0, make_redirect(1'b1, 32'(MEM_WORDS * 4)), '0);
		expect_fetch(32'(MEM_WORDS * 4), 1'b1);
		retire_with(make_redirect(1'b1, 32'hffff_fffc), '0, '0);
		expect_fetch(32'hffff_fffc, 1'b1);
	endtask

	task automatic test_shared_channel();
		logic [31:0] addrs [8];
		// even loads hit the memory, odd ones land past its end
		for (int k = 0; k < 8; k++) begin
			if (k % 2 == 0) begin
				addrs[k] = ($urandom % 32'(MEM_WORDS)) << 2;
			end else begin
				addrs[k] = 32'(MEM_WORDS * 4) + (($urandom % 32'd512) << 2);
			end
		end
		fork
			begin
				for (int k = 0; k < 8; k++) begin
					if (k == 0) begin
						retire_with('0, make_redirect(1'b1, 32'h40), '0);
					end else begin
						retire_with('0, '0, '0);
					end
					expect_fetch(32'h40 + 32'(4 * k), 1'b0);
				end
			end
			begin
				for (int k = 0; k < 8; k++) begin
					run_load(addrs[k]);
				end
			end
		join
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		check_count  = 0;
		error_count  = 0;
		cycle_count  = 0;
		assert_fails = 0;
		rst          = 1'b1;
		retire       = 1'b0;
		trap         = '0;
		jump         = '0;
		branch       = '0;
		load_req     = 1'b0;
		load_addr    = 32'h0;
		mem_we       = 1'b0;
		mem_waddr    = 32'h0;
		mem_wdata    = 32'h0;
		apply_reset();
		check_reset_state();
		test_sequential();
		// rest of the memory, fetch sits waiting for retire meanwhile
		fill_range(RESET_CYCLES, MEM_WORDS - 1);
		test_redirect_priority();
		test_legality();
		test_fault();
		test_shared_channel();
		assert_fails = i_dut.i_rd_arbiter.i_rd_arbiter_assert.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
			assert_fails);
		if ((error_count == 0) && (assert_fails == 0)) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* src.f */
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/inst_check.sv
verilog/ifetch.sv
verilog/load_port.sv
verilog/rd_arbiter.sv
verilog/mem_slave.sv
verilog/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

/* Makefile */
SIM      = verilator
TOP      = fetch_tb
FILELIST = src.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
